// File: build.f
logic/ntm_oneplus_pkg.sv
logic/ntm_oneplus_decode.sv
logic/ntm_oneplus_execute.sv
logic/ntm_oneplus_result.sv
logic/ntm_vector_oneplus_top.sv
verification/tb_ntm_vector_oneplus.sv

// File: Makefile
# Verilator lint and simulation of the vector oneplus unit

TOP = tb_ntm_vector_oneplus

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -f build.f --top-module ntm_vector_oneplus_top
	verilator --lint-only --timing --timescale 1ns/1ns -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f build.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: verification/tb_ntm_vector_oneplus.sv
// Testbench for the vector oneplus unit; drives credited commands and checks results each clock
`timescale 1ns/1ns

module tb_ntm_vector_oneplus
  import ntm_oneplus_pkg::*;
();

  localparam int WAIT_LIMIT = 2000;
  localparam int NUM_DIR    = 11;

  // DUT ports
  logic                  CLK;
  logic                  RST;
  logic                  START;
  opcode_t               OPCODE;
  logic [LEN_WIDTH-1:0]  LENGTH;
  logic                  BUSY;
  logic                  DATA_IN_VALID;
  logic [DATA_WIDTH-1:0] DATA_IN;
  logic                  IN_CREDIT;
  logic                  DATA_OUT_VALID;
  logic [DATA_WIDTH-1:0] DATA_OUT;
  logic                  OUT_CREDIT;
  logic                  DONE;

  // Expected results in send order
  logic [DATA_WIDTH-1:0] exp_data [1024];
  logic                  exp_last [1024];
  logic [9:0]            exp_wr;
  logic [9:0]            exp_rd;

  // Bookkeeping
  int          sender_credits;
  int          out_sent;
  int          out_returned;
  int          done_count;
  int          cmd_count;
  logic        busy_q;
  logic        start_q;
  logic        started;
  logic        stress;
  logic [31:0] rng;
  int          check_errors = 0;
  int          final_errors = 0;
  int          timeouts     = 0;

  ntm_vector_oneplus_top UUT (.*);

  always #4 CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Three region softplus, optional +1.0, saturate
  function automatic logic [DATA_WIDTH-1:0] model(input logic [DATA_WIDTH-1:0] x,
                                                  input opcode_t op);
    int xs;
    int base;
    xs = int'($signed(x));
    if (xs <= -1024) begin
      base = 0;
    end else if (xs >= 1024) begin
      base = xs;
    end else begin
      // (x + 4.0)^2 / 16 back in Q8.8
      base = ((xs + 1024) * (xs + 1024)) >> 12;
    end
    if (op == OP_ONEPLUS) begin
      base = base + 256;
    end
    if (base > 32767) begin
      base = 32767;
    end
    return base[DATA_WIDTH-1:0];
  endfunction

  // Knees, neighbours, zero and saturating values
  function automatic logic [DATA_WIDTH-1:0] directed_value(input int k);
    case (k)
      0:       return 16'hfc00;
      1:       return 16'h0400;
      2:       return 16'hfbff;
      3:       return 16'hfc01;
      4:       return 16'h03ff;
      5:       return 16'h0401;
      6:       return 16'h0000;
      7:       return 16'h7fff;
      8:       return 16'h7f00;
      9:       return 16'h8000;
      default: return 16'h0100;
    endcase
  endfunction

  task automatic finish_run();
    $display("errors: check %0d, final %0d, timeout %0d", check_errors, final_errors, timeouts);
    if (check_errors == 0 && final_errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout while waiting for %s", what);
    finish_run();
  endtask

  task automatic run_command(input opcode_t op, input int len, input bit directed);
    int n;
    int sent;
    int v_int;
    logic [DATA_WIDTH-1:0] v;
    n = 0;
    while (BUSY) begin
      if (n == WAIT_LIMIT) report_timeout("BUSY to fall before the next command");
      n++;
      @(posedge CLK);
      #1;
    end
    START   = 1'b1;
    OPCODE  = op;
    LENGTH  = len[LEN_WIDTH-1:0];
    started = 1'b1;
    @(posedge CLK);
    #1;
    START = 1'b0;
    // Command fields change while the command runs
    OPCODE = (op == OP_ONEPLUS) ? OP_SOFTPLUS : OP_ONEPLUS;
    LENGTH = ~LENGTH;
    cmd_count++;
    sent = 0;
    while (sent < len) begin
      n = 0;
      // Send only while busy and holding a credit
      while (!(BUSY && sender_credits > 0)) begin
        if (n == WAIT_LIMIT) report_timeout("an input credit");
        n++;
        @(posedge CLK);
        #1;
      end
      rng = lcg_step(rng);
      if (directed) begin
        v = directed_value(sent % NUM_DIR);
      end else if (rng[31]) begin
        v = rng[15:0];
      end else begin
        // Mostly around the knees
        v_int = int'(rng[27:16]) % 2560 - 1280;
        v     = v_int[DATA_WIDTH-1:0];
      end
      DATA_IN          = v;
      DATA_IN_VALID    = 1'b1;
      exp_data[exp_wr] = model(v, op);
      exp_last[exp_wr] = (sent == len - 1);
      exp_wr           = exp_wr + 10'd1;
      sent++;
      @(posedge CLK);
      #1;
      DATA_IN_VALID = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Consumer with random credit returns
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rc;
    int          hold;
    OUT_CREDIT = 1'b0;
    rc   = 32'h32f9;
    hold = 0;
    forever begin
      @(posedge CLK);
      #1;
      rc = lcg_step(rc);
      OUT_CREDIT = 1'b0;
      if (hold > 0) begin
        hold--;
      end else if (stress && rc[29:24] == 6'd0) begin
        // Long stretch without credits
        hold = 30 + int'(rc[20:16]);
      end else if (out_sent > out_returned && rc[5:4] != 2'd0) begin
        OUT_CREDIT = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Clocked checks
  ////////////////////////////////////////////////////////////

  always @(posedge CLK or posedge RST) begin
    if (RST) begin
      sender_credits <= IN_DEPTH;
      out_sent       <= 0;
      out_returned   <= 0;
      done_count     <= 0;
      exp_rd         <= '0;
      busy_q         <= 1'b0;
      start_q        <= 1'b0;
    end else begin
      sender_credits <= sender_credits - int'(DATA_IN_VALID) + int'(IN_CREDIT);
      if (DATA_OUT_VALID) begin
        out_sent <= out_sent + 1;
        exp_rd   <= exp_rd + 10'd1;
      end
      if (OUT_CREDIT) out_returned <= out_returned + 1;
      if (DONE) done_count <= done_count + 1;
      busy_q  <= BUSY;
      start_q <= START && !BUSY;

      // Reset values hold until the first command
      if (!started) begin
        assert (!BUSY && !IN_CREDIT && !DATA_OUT_VALID && !DONE) else begin
          check_errors++;
          $display("error idle outputs BUSY=%h IN_CREDIT=%h DATA_OUT_VALID=%h DONE=%h",
                   BUSY, IN_CREDIT, DATA_OUT_VALID, DONE);
        end
      end
      assert (sender_credits >= 0 && sender_credits <= IN_DEPTH) else begin
        check_errors++;
        $display("error sender_credits %h outside 0 to %h", sender_credits, IN_DEPTH);
      end
      // Every input credit back once the command has issued
      if (busy_q && !BUSY) begin
        assert (sender_credits == IN_DEPTH) else begin
          check_errors++;
          $display("error sender_credits %h expected %h", sender_credits, IN_DEPTH);
        end
      end
      if (start_q) begin
        assert (BUSY) else begin
          check_errors++;
          $display("BUSY did not rise in the cycle after START");
        end
      end
      assert (out_sent + int'(DATA_OUT_VALID) <= OUT_CREDITS_INIT + out_returned) else begin
        check_errors++;
        $display("more outputs than credits: %0d sent, %0d returned", out_sent, out_returned);
      end
      assert (!DONE || DATA_OUT_VALID) else begin
        check_errors++;
        $display("DONE pulsed without an output element");
      end
      if (DATA_OUT_VALID) begin
        assert (exp_rd != exp_wr) else begin
          check_errors++;
          $display("DUT sent an element that was never expected");
        end
        if (exp_rd != exp_wr) begin
          assert (DATA_OUT == exp_data[exp_rd]) else begin
            check_errors++;
            $display("error DATA_OUT got %h expected %h", DATA_OUT, exp_data[exp_rd]);
          end
          assert (DONE == exp_last[exp_rd]) else begin
            check_errors++;
            $display("error DONE got %h expected %h", DONE, exp_last[exp_rd]);
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int n;
    CLK           = 1'b0;
    RST           = 1'b1;
    START         = 1'b0;
    OPCODE        = OP_SOFTPLUS;
    LENGTH        = '0;
    DATA_IN_VALID = 1'b0;
    DATA_IN       = '0;
    started       = 1'b0;
    stress        = 1'b0;
    cmd_count     = 0;
    exp_wr        = '0;
    rng           = 32'h32f9;
    repeat (8) @(posedge CLK);
    #1;
    RST = 1'b0;
    // Quiet window after reset
    repeat (10) @(posedge CLK);
    #1;
    run_command(OP_SOFTPLUS, NUM_DIR, 1'b1);
    run_command(OP_ONEPLUS, NUM_DIR, 1'b1);
    run_command(OP_ONEPLUS, 1, 1'b0);
    stress = 1'b1;
    run_command(OP_SOFTPLUS, 255, 1'b0);
    // Back to back with mixed opcodes
    for (int i = 0; i < 14; i++) begin
      rng = lcg_step(rng);
      run_command(opcode_t'(rng[30]), int'(rng[19:16]) + 1, 1'b0);
    end
    stress = 1'b0;
    n = 0;
    while (exp_rd != exp_wr) begin
      if (n == WAIT_LIMIT) report_timeout("the last results to drain");
      n++;
      @(posedge CLK);
      #1;
    end
    repeat (2) @(posedge CLK);
    #1;
    assert (done_count == cmd_count) else begin
      final_errors++;
      $display("error done_count %h expected %h", done_count, cmd_count);
    end
    assert (sender_credits == IN_DEPTH) else begin
      final_errors++;
      $display("error sender_credits %h expected %h", sender_credits, IN_DEPTH);
    end
    finish_run();
  end

endmodule

// File: logic/ntm_vector_oneplus_top.sv
// Top of the vector oneplus unit; wires decode, execute and result into one credit-managed pipeline
`timescale 1ns/1ns

module ntm_vector_oneplus_top
  import ntm_oneplus_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  // Command
  input  logic                  START,
  input  opcode_t               OPCODE,
  input  logic [LEN_WIDTH-1:0]  LENGTH,
  output logic                  BUSY,
  // Input stream
  input  logic                  DATA_IN_VALID,
  input  logic [DATA_WIDTH-1:0] DATA_IN,
  output logic                  IN_CREDIT,
  // Output stream
  output logic                  DATA_OUT_VALID,
  output logic [DATA_WIDTH-1:0] DATA_OUT,
  input  logic                  OUT_CREDIT,
  // Completion
  output logic                  DONE
);

  ////////////////////////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////////////////////////

  // Decode to execute
  logic                  issue_valid;
  logic [DATA_WIDTH-1:0] issue_data;
  opcode_t               issue_op;
  logic                  issue_last;

  // Execute to result
  logic                  exec_valid;
  logic [DATA_WIDTH-1:0] exec_data;
  logic                  exec_last;

  // Result slot return
  logic                  res_credit;

  ////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////

  ntm_oneplus_decode u_decode (
    .CLK           (CLK),
    .RST           (RST),
    .START         (START),
    .OPCODE        (OPCODE),
    .LENGTH        (LENGTH),
    .BUSY          (BUSY),
    .DATA_IN_VALID (DATA_IN_VALID),
    .DATA_IN       (DATA_IN),
    .IN_CREDIT     (IN_CREDIT),
    .res_credit    (res_credit),
    .issue_valid   (issue_valid),
    .issue_data    (issue_data),
    .issue_op      (issue_op),
    .issue_last    (issue_last)
  );

  // Fixed two cycle latency, no stall
  ntm_oneplus_execute u_execute (
    .CLK         (CLK),
    .RST         (RST),
    .issue_valid (issue_valid),
    .issue_data  (issue_data),
    .issue_op    (issue_op),
    .issue_last  (issue_last),
    .exec_valid  (exec_valid),
    .exec_data   (exec_data),
    .exec_last   (exec_last)
  );

  ntm_oneplus_result u_result (
    .CLK            (CLK),
    .RST            (RST),
    .exec_valid     (exec_valid),
    .exec_data      (exec_data),
    .exec_last      (exec_last),
    .res_credit     (res_credit),
    .DATA_OUT_VALID (DATA_OUT_VALID),
    .DATA_OUT       (DATA_OUT),
    .OUT_CREDIT     (OUT_CREDIT),
    .DONE           (DONE)
  );

endmodule

// File: logic/ntm_oneplus_result.sv
// Result buffer and output credit gate; returns slots to decode and flags command completion
`timescale 1ns/1ns

module ntm_oneplus_result
  import ntm_oneplus_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  // From execute
  input  logic                  exec_valid,
  input  logic [DATA_WIDTH-1:0] exec_data,
  input  logic                  exec_last,
  // Slot return to decode
  output logic                  res_credit,
  // Output stream
  output logic                  DATA_OUT_VALID,
  output logic [DATA_WIDTH-1:0] DATA_OUT,
  input  logic                  OUT_CREDIT,
  // Last element of a command leaving
  output logic                  DONE
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // Result FIFO, data plus last tag
  logic [DATA_WIDTH-1:0] res_mem [RES_DEPTH];
  logic                  last_mem [RES_DEPTH];
  logic [RES_PTR_W-1:0]  wr_ptr;
  logic [RES_PTR_W-1:0]  rd_ptr;
  logic [RES_CNT_W-1:0]  res_count;
  logic                  res_empty;
  logic                  res_full;

  // Consumer buffer space
  logic [OUT_CNT_W-1:0]  out_credits;
  logic                  pop;

  ////////////////////////////////////////////////////////////
  // Pop
  ////////////////////////////////////////////////////////////

  assign res_empty = (res_count == '0);
  assign res_full  = (res_count == RES_CNT_W'(RES_DEPTH));

  // Needs an entry and a consumer credit
  assign pop = !res_empty && (out_credits != '0);

  assign DATA_OUT_VALID = pop;
  assign DATA_OUT       = res_mem[rd_ptr];
  assign DONE           = pop && last_mem[rd_ptr];
  // Freed slot goes back to decode
  assign res_credit     = pop;

  ////////////////////////////////////////////////////////////
  // FIFO
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (exec_valid) begin
      res_mem[wr_ptr]  <= exec_data;
      last_mem[wr_ptr] <= exec_last;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      res_count <= '0;
    end else begin
      if (exec_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({exec_valid, pop})
        2'b10:   res_count <= res_count + 1'b1;
        2'b01:   res_count <= res_count - 1'b1;
        default: res_count <= res_count;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Output credits
  ////////////////////////////////////////////////////////////

  // Gain on OUT_CREDIT, spend on each output
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_credits <= OUT_CNT_W'(OUT_CREDITS_INIT);
    end else begin
      case ({OUT_CREDIT, pop})
        2'b10:   out_credits <= out_credits + 1'b1;
        2'b01:   out_credits <= out_credits - 1'b1;
        default: out_credits <= out_credits;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Decode's slot count must keep execute from overrunning the buffer
  a_no_write_full: assert property (@(posedge CLK) disable iff (RST)
    exec_valid |-> !res_full);

  // Consumer never returns more than it was given
  a_out_credit_bound: assert property (@(posedge CLK) disable iff (RST)
    out_credits <= OUT_CNT_W'(OUT_CREDITS_INIT));

endmodule

// File: logic/ntm_oneplus_execute.sv
// Two-stage softplus and oneplus datapath; carries opcode and last tag alongside each element
`timescale 1ns/1ns

module ntm_oneplus_execute
  import ntm_oneplus_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  // From decode
  input  logic                  issue_valid,
  input  logic [DATA_WIDTH-1:0] issue_data,
  input  opcode_t               issue_op,
  input  logic                  issue_last,
  // To result, two cycles after issue
  output logic                  exec_valid,
  output logic [DATA_WIDTH-1:0] exec_data,
  output logic                  exec_last
);

  ////////////////////////////////////////////////////////////
  // Stage one registers
  ////////////////////////////////////////////////////////////

  logic                         s1_valid;
  opcode_t                      s1_op;
  logic                         s1_last;
  logic                         s1_low;
  logic                         s1_high;
  logic        [DATA_WIDTH-1:0] s1_data;
  logic signed [DATA_WIDTH-1:0] s1_sum;

  // Stage two combinational
  logic signed [2*DATA_WIDTH-1:0] sq_prod;
  logic        [2*DATA_WIDTH-1:0] base;
  logic        [2*DATA_WIDTH-1:0] total;
  logic        [DATA_WIDTH-1:0]   result_d;

  ////////////////////////////////////////////////////////////
  // Stage one: region and shifted input
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue_valid;
    end
  end

  always_ff @(posedge CLK) begin
    s1_op   <= issue_op;
    s1_last <= issue_last;
    s1_data <= issue_data;
    // At or below -4.0 gives zero
    s1_low  <= ($signed(issue_data) <= -KNEE);
    // At or above 4.0 passes through
    s1_high <= ($signed(issue_data) >= KNEE);
    // Only meaningful in the middle region, never wraps there
    s1_sum  <= $signed(issue_data) + KNEE;
  end

  ////////////////////////////////////////////////////////////
  // Stage two: square, select, offset, saturate
  ////////////////////////////////////////////////////////////

  // (x + 4)^2 as Q16.16
  assign sq_prod = s1_sum * s1_sum;

  always_comb begin
    if (s1_low) begin
      base = '0;
    end else if (s1_high) begin
      // Positive here, zero extend
      base = {{DATA_WIDTH{1'b0}}, s1_data};
    end else begin
      // Divide by 16 and drop to Q8.8, truncating
      base = $unsigned(sq_prod) >> SQ_SHIFT;
    end
    // Oneplus offset
    if (s1_op == OP_ONEPLUS) begin
      total = base + (2*DATA_WIDTH)'(ONE_FIX);
    end else begin
      total = base;
    end
    // Clamp to largest positive
    if (total > (2*DATA_WIDTH)'(MAX_FIX)) begin
      result_d = MAX_FIX;
    end else begin
      result_d = total[DATA_WIDTH-1:0];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      exec_valid <= 1'b0;
    end else begin
      exec_valid <= s1_valid;
    end
  end

  // Payload follows valid
  always_ff @(posedge CLK) begin
    exec_data <= result_d;
    exec_last <= s1_last;
  end

endmodule

// File: logic/ntm_oneplus_decode.sv
// Command intake and input buffer; issues tagged elements to execute while result slots remain
`timescale 1ns/1ns

module ntm_oneplus_decode
  import ntm_oneplus_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,
  // Command
  input  logic                  START,
  input  opcode_t               OPCODE,
  input  logic [LEN_WIDTH-1:0]  LENGTH,
  output logic                  BUSY,
  // Input stream
  input  logic                  DATA_IN_VALID,
  input  logic [DATA_WIDTH-1:0] DATA_IN,
  output logic                  IN_CREDIT,
  // Slot return from result
  input  logic                  res_credit,
  // Issue to execute
  output logic                  issue_valid,
  output logic [DATA_WIDTH-1:0] issue_data,
  output opcode_t               issue_op,
  output logic                  issue_last
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  decode_state_t         state;
  opcode_t               op_q;
  logic [LEN_WIDTH-1:0]  len_q;
  logic [LEN_WIDTH-1:0]  issued;

  // Input FIFO
  logic [DATA_WIDTH-1:0] in_mem [IN_DEPTH];
  logic [IN_PTR_W-1:0]   wr_ptr;
  logic [IN_PTR_W-1:0]   rd_ptr;
  logic [IN_CNT_W-1:0]   in_count;
  logic                  in_empty;
  logic                  in_full;

  // Free result slots
  logic [RES_CNT_W-1:0]  exec_credits;

  ////////////////////////////////////////////////////////////
  // Issue
  ////////////////////////////////////////////////////////////

  assign in_empty = (in_count == '0);
  assign in_full  = (in_count == IN_CNT_W'(IN_DEPTH));

  // Needs a running command, a buffered element and a result slot
  assign issue_valid = (state == ST_RUN) && !in_empty && (exec_credits != '0);
  assign issue_data  = in_mem[rd_ptr];
  assign issue_op    = op_q;
  assign issue_last  = (issued == len_q - 1'b1);

  // Every pop frees one sender slot
  assign IN_CREDIT = issue_valid;
  assign BUSY      = (state == ST_RUN);

  ////////////////////////////////////////////////////////////
  // Command FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= ST_IDLE;
      op_q   <= OP_SOFTPLUS;
      len_q  <= '0;
      issued <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Latch command, START ignored while busy
          if (START) begin
            op_q   <= OPCODE;
            len_q  <= LENGTH;
            issued <= '0;
            state  <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (issue_valid) begin
            // Last element ends the command
            if (issue_last) begin
              state <= ST_IDLE;
            end else begin
              issued <= issued + 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Input FIFO and execute credits
  ////////////////////////////////////////////////////////////

  // Storage only
  always_ff @(posedge CLK) begin
    if (DATA_IN_VALID) begin
      in_mem[wr_ptr] <= DATA_IN;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      in_count     <= '0;
      exec_credits <= RES_CNT_W'(RES_DEPTH);
    end else begin
      if (DATA_IN_VALID) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (issue_valid) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Occupancy
      case ({DATA_IN_VALID, issue_valid})
        2'b10:   in_count <= in_count + 1'b1;
        2'b01:   in_count <= in_count - 1'b1;
        default: in_count <= in_count;
      endcase
      // One slot taken per issue, one back per result pop
      case ({issue_valid, res_credit})
        2'b10:   exec_credits <= exec_credits - 1'b1;
        2'b01:   exec_credits <= exec_credits + 1'b1;
        default: exec_credits <= exec_credits;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Sender must respect its credits
  a_no_push_full: assert property (@(posedge CLK) disable iff (RST)
    DATA_IN_VALID |-> !in_full);

  // New command only once the previous one has issued
  a_no_start_busy: assert property (@(posedge CLK) disable iff (RST)
    START |-> !BUSY);

  // Result never returns more slots than it has
  a_credit_bound: assert property (@(posedge CLK) disable iff (RST)
    exec_credits <= RES_CNT_W'(RES_DEPTH));

endmodule

// File: logic/ntm_oneplus_pkg.sv
// Shared widths, depths, fixed point constants and enums; imported by every activation unit module
package ntm_oneplus_pkg;

  ////////////////////////////////////////////////////////////
  // Data format
  ////////////////////////////////////////////////////////////

  // Signed Q8.8 elements
  localparam int DATA_WIDTH = 16;
  localparam int FRAC_BITS  = 8;

  // Vector length, zero not allowed
  localparam int LEN_WIDTH = 8;

  // Square is Q16.16, divide by 16 and return to Q8.8
  localparam int SQ_SHIFT = FRAC_BITS + 4;

  ////////////////////////////////////////////////////////////
  // Buffers and credits
  ////////////////////////////////////////////////////////////

  localparam int IN_DEPTH         = 4;
  localparam int RES_DEPTH        = 4;
  localparam int OUT_CREDITS_INIT = 4;

  // Pointer and occupancy widths
  localparam int IN_PTR_W  = $clog2(IN_DEPTH);
  localparam int IN_CNT_W  = $clog2(IN_DEPTH) + 1;
  localparam int RES_PTR_W = $clog2(RES_DEPTH);
  localparam int RES_CNT_W = $clog2(RES_DEPTH) + 1;
  localparam int OUT_CNT_W = $clog2(OUT_CREDITS_INIT) + 1;

  ////////////////////////////////////////////////////////////
  // Fixed point constants
  ////////////////////////////////////////////////////////////

  // 4.0, the softplus knee
  localparam logic signed [DATA_WIDTH-1:0] KNEE    = 16'sd1024;
  // 1.0, oneplus offset
  localparam logic        [DATA_WIDTH-1:0] ONE_FIX = 16'd256;
  // Largest positive Q8.8
  localparam logic        [DATA_WIDTH-1:0] MAX_FIX = 16'h7fff;

  ////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    OP_SOFTPLUS = 1'b0,
    OP_ONEPLUS  = 1'b1
  } opcode_t;

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RUN  = 1'b1
  } decode_state_t;

endpackage
